/* common/rhythm_pkg.sv */
package rhythm_pkg;

    // Chart or key note: {oct_down, oct_up, keys B..C}
    typedef logic [8:0] note_t;

    // Position in the chart
    typedef logic [15:0] note_idx_t;

    typedef logic [13:0] score_t;

    // Save slot number
    typedef logic [7:0] chart_id_t;

    // Countdown digit 3..0
    typedef logic [1:0] cnt_digit_t;

    typedef logic [7:0] led_t;

    // Eight ASCII characters, first character in the top byte
    typedef logic [63:0] seg_text_t;

    typedef enum logic [1:0] {
        COUNTDOWN,
        PLAYING,
        FINISHED,
        EXITED
    } play_state_t;

    // Points per scored scan
    localparam score_t MAX_STEP = 14'd5;
    localparam score_t AUTO_STEP = 14'd4;

    // Timing grades, by how late the matching key was sampled
    localparam score_t HIT_NOW = 14'd5;
    localparam score_t HIT_LATE1 = 14'd3;
    localparam score_t HIT_LATE2 = 14'd2;

endpackage

/* common/step_if.sv */
`timescale 1ns/100ps

// Play enable, chart position and tick strobes shared by the play blocks
interface step_if;

    logic play_en;
    rhythm_pkg::note_idx_t note_idx;
    logic note_tick;
    logic scan_tick;

    modport timer (
        input  play_en,
        output note_tick,
        output scan_tick
    );

    modport fsm (
        output play_en,
        output note_idx,
        input  note_tick
    );

    modport user (
        input  play_en,
        input  note_idx,
        input  note_tick,
        input  scan_tick
    );

endinterface

/* rhythm_play.f */
common/rhythm_pkg.sv
common/step_if.sv
rtl/step_timer.sv
rtl/play_fsm.sv
rtl/score_unit.sv
rtl/note_display.sv
rtl/note_recorder.sv
rtl/rhythm_play.sv
tests/rhythm_play_checker.sv
tests/tb_rhythm_play.sv

/* rtl/note_display.sv */
`timescale 1ns/100ps

module note_display (
    input  logic                  prog_clk,
    input  logic                  rst,
    step_if.user                  step,
    input  rhythm_pkg::note_t     chart_note,
    output rhythm_pkg::led_t      led,
    output rhythm_pkg::seg_text_t seg
);

    localparam rhythm_pkg::seg_text_t BLANK = "        ";
    localparam logic [55:0] LETTERS = "cdefgab";

    logic key_ok;
    logic [2:0] key_pos;
    logic [6:0] key_rev;
    logic [7:0] letter;
    logic [7:0] digit;
    logic [7:0] oct_char;
    logic note_ok;
    rhythm_pkg::led_t led_next;
    rhythm_pkg::seg_text_t seg_next;

    // Find the single key, reversing for the LED order on the way
    always_comb begin
        key_ok = 1'b0;
        key_pos = '0;
        for (int i = 0; i < 7; i++) begin
            key_rev[6 - i] = chart_note[i];
            if (chart_note[6:0] == 7'(1 << i)) begin
                key_ok = 1'b1;
                key_pos = 3'(i);
            end
        end
    end

    assign letter = LETTERS[8 * (6 - key_pos) +: 8];
    assign digit = "1" + {5'd0, key_pos};

    always_comb begin
        case (chart_note[8:7])
            2'b01: oct_char = "u";
            2'b10: oct_char = "d";
            default: oct_char = " ";
        endcase
    end

    // Both octave bits at once is not a playable note
    assign note_ok = key_ok && (chart_note[8:7] != 2'b11);

    assign seg_next = note_ok ? {letter, " ", oct_char, " ", digit, "   "} : BLANK;

    // C lights the top LED, octave shift shows on LED 0
    assign led_next = {key_ok ? key_rev : 7'd0, ^chart_note[8:7]};

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            led <= '0;
            seg <= BLANK;
        end else if (step.play_en) begin
            led <= led_next;
            seg <= seg_next;
        end
    end

endmodule

/* rtl/note_recorder.sv */
`timescale 1ns/100ps

module note_recorder (
    input  logic                  prog_clk,
    input  logic                  rst,
    step_if.user                  step,
    input  rhythm_pkg::note_t     chart_note,
    input  logic [6:0]            note_keys,
    input  logic                  oct_up,
    input  logic                  oct_down,
    input  logic                  auto_play,
    output rhythm_pkg::note_t     played_note,
    output logic                  rec_we,
    output rhythm_pkg::note_idx_t rec_addr,
    output rhythm_pkg::note_t     rec_note
);

    rhythm_pkg::note_t key_note;
    logic step_en;

    assign key_note = {oct_down, oct_up, note_keys};
    assign step_en = step.play_en && step.note_tick;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            rec_we <= 1'b0;
            played_note <= '0;
        end else begin
            rec_we <= step_en;
            if (step_en) begin
                played_note <= auto_play ? chart_note : key_note;
            end
        end
    end

    // One record word per note, at the index before it advances
    always_ff @(posedge prog_clk) begin
        if (step_en) begin
            rec_addr <= step.note_idx;
            rec_note <= key_note;
        end
    end

endmodule

/* rtl/play_fsm.sv */
`timescale 1ns/100ps

module play_fsm (
    input  logic                   prog_clk,
    input  logic                   rst,
    step_if.fsm                    step,
    input  logic                   sec_tick,
    input  rhythm_pkg::note_idx_t  note_cnt,
    input  logic                   key_left,
    input  logic                   key_right,
    input  rhythm_pkg::score_t     score,
    input  rhythm_pkg::score_t     max_score,
    input  rhythm_pkg::chart_id_t  chart_id,
    output rhythm_pkg::cnt_digit_t cnt_dn,
    output logic                   to_menu,
    output logic                   save_strobe,
    output rhythm_pkg::chart_id_t  save_chart_id,
    output rhythm_pkg::score_t     save_score,
    output rhythm_pkg::score_t     save_max
);

    rhythm_pkg::play_state_t state;
    rhythm_pkg::note_idx_t next_idx;
    logic in_game;
    logic save_req;

    assign next_idx = step.note_idx + rhythm_pkg::note_idx_t'(1);

    // Keys only act once the countdown is over
    assign in_game = (state == rhythm_pkg::PLAYING) || (state == rhythm_pkg::FINISHED);
    assign save_req = in_game && key_right;

    assign step.play_en = (state == rhythm_pkg::PLAYING);
    assign to_menu = (state == rhythm_pkg::EXITED);

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state <= rhythm_pkg::COUNTDOWN;
            cnt_dn <= 2'd3;
            step.note_idx <= '0;
        end else begin
            case (state)
                rhythm_pkg::COUNTDOWN: begin
                    if (sec_tick) begin
                        if (cnt_dn != 2'd0) begin
                            cnt_dn <= cnt_dn - 2'd1;
                        end else begin
                            state <= rhythm_pkg::PLAYING;
                        end
                    end
                end
                rhythm_pkg::PLAYING: begin
                    if (key_left) begin
                        state <= rhythm_pkg::EXITED;
                    end else if (step.note_tick) begin
                        step.note_idx <= next_idx;
                        // Zero length means an endless chart
                        if (note_cnt != '0 && next_idx == note_cnt) begin
                            state <= rhythm_pkg::FINISHED;
                        end
                    end
                end
                rhythm_pkg::FINISHED: begin
                    if (key_left) begin
                        state <= rhythm_pkg::EXITED;
                    end
                end
                default: begin
                    state <= rhythm_pkg::EXITED;
                end
            endcase
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            save_strobe <= 1'b0;
        end else begin
            save_strobe <= save_req;
        end
    end

    // Save payload, valid alongside save_strobe
    always_ff @(posedge prog_clk) begin
        if (save_req) begin
            save_chart_id <= chart_id;
            save_score <= score;
            save_max <= max_score;
        end
    end

endmodule

/* rtl/rhythm_play.sv */
`timescale 1ns/100ps

module rhythm_play #(
    parameter int COUNT_TICKS = 8,
    parameter int NOTE_TICKS = 12,
    parameter int SCAN_TICKS = 4
) (
    input  logic                   prog_clk,
    input  logic                   rst,
    input  logic [6:0]             note_keys,
    input  logic                   oct_up,
    input  logic                   oct_down,
    input  logic                   key_left,
    input  logic                   key_right,
    input  logic                   auto_play,
    input  rhythm_pkg::chart_id_t  chart_id,
    input  rhythm_pkg::note_idx_t  note_cnt,
    output rhythm_pkg::note_idx_t  chart_addr,
    input  rhythm_pkg::note_t      chart_note,
    output rhythm_pkg::cnt_digit_t cnt_dn,
    output logic                   playing,
    output logic                   to_menu,
    output rhythm_pkg::led_t       led,
    output rhythm_pkg::seg_text_t  seg,
    output rhythm_pkg::note_t      played_note,
    output logic                   rec_we,
    output rhythm_pkg::note_idx_t  rec_addr,
    output rhythm_pkg::note_t      rec_note,
    output logic                   save_strobe,
    output rhythm_pkg::chart_id_t  save_chart_id,
    output rhythm_pkg::score_t     save_score,
    output rhythm_pkg::score_t     save_max
);

    step_if step ();

    logic sec_tick;
    rhythm_pkg::score_t score;
    rhythm_pkg::score_t max_score;

    // Chart memory is addressed directly by the play position
    assign chart_addr = step.note_idx;
    assign playing = step.play_en;

    step_timer #(
        .COUNT_TICKS (COUNT_TICKS),
        .NOTE_TICKS  (NOTE_TICKS),
        .SCAN_TICKS  (SCAN_TICKS)
    ) timer0 (
        .prog_clk (prog_clk),
        .rst      (rst),
        .step     (step.timer),
        .sec_tick (sec_tick)
    );

    play_fsm fsm0 (
        .prog_clk      (prog_clk),
        .rst           (rst),
        .step          (step.fsm),
        .sec_tick      (sec_tick),
        .note_cnt      (note_cnt),
        .key_left      (key_left),
        .key_right     (key_right),
        .score         (score),
        .max_score     (max_score),
        .chart_id      (chart_id),
        .cnt_dn        (cnt_dn),
        .to_menu       (to_menu),
        .save_strobe   (save_strobe),
        .save_chart_id (save_chart_id),
        .save_score    (save_score),
        .save_max      (save_max)
    );

    score_unit score0 (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .step       (step.user),
        .chart_note (chart_note),
        .note_keys  (note_keys),
        .oct_up     (oct_up),
        .oct_down   (oct_down),
        .auto_play  (auto_play),
        .score      (score),
        .max_score  (max_score)
    );

    note_display disp0 (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .step       (step.user),
        .chart_note (chart_note),
        .led        (led),
        .seg        (seg)
    );

    note_recorder rec0 (
        .prog_clk    (prog_clk),
        .rst         (rst),
        .step        (step.user),
        .chart_note  (chart_note),
        .note_keys   (note_keys),
        .oct_up      (oct_up),
        .oct_down    (oct_down),
        .auto_play   (auto_play),
        .played_note (played_note),
        .rec_we      (rec_we),
        .rec_addr    (rec_addr),
        .rec_note    (rec_note)
    );

endmodule

/* rtl/score_unit.sv */
`timescale 1ns/100ps

module score_unit (
    input  logic               prog_clk,
    input  logic               rst,
    step_if.user               step,
    input  rhythm_pkg::note_t  chart_note,
    input  logic [6:0]         note_keys,
    input  logic               oct_up,
    input  logic               oct_down,
    input  logic               auto_play,
    output rhythm_pkg::score_t score,
    output rhythm_pkg::score_t max_score
);

    rhythm_pkg::note_t key_note;
    // Key samples from the last two pressed scans, [0] is newest
    rhythm_pkg::note_t key_hist [2];
    logic scan_en;

    assign key_note = {oct_down, oct_up, note_keys};

    // Rests are never scored
    assign scan_en = step.play_en && step.scan_tick && (chart_note[6:0] != 7'd0);

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            score <= '0;
            max_score <= '0;
            key_hist[0] <= '0;
            key_hist[1] <= '0;
        end else if (scan_en) begin
            max_score <= max_score + rhythm_pkg::MAX_STEP;
            if (auto_play) begin
                score <= score + rhythm_pkg::AUTO_STEP;
            end else if (note_keys != 7'd0) begin
                key_hist[0] <= key_note;
                key_hist[1] <= key_hist[0];
                // Earlier match earns fewer points
                if (key_note == chart_note) begin
                    score <= score + rhythm_pkg::HIT_NOW;
                end else if (key_hist[0] == chart_note) begin
                    score <= score + rhythm_pkg::HIT_LATE1;
                end else if (key_hist[1] == chart_note) begin
                    score <= score + rhythm_pkg::HIT_LATE2;
                end
            end
        end
    end

endmodule

/* rtl/step_timer.sv */
`timescale 1ns/100ps

module step_timer #(
    parameter int COUNT_TICKS = 8,
    parameter int NOTE_TICKS = 12,
    parameter int SCAN_TICKS = 4
) (
    input  logic  prog_clk,
    input  logic  rst,
    step_if.timer step,
    output logic  sec_tick
);

    localparam int SEC_W = $clog2(COUNT_TICKS + 1);
    // Note period is the longest of the play periods
    localparam int PLAY_W = $clog2(NOTE_TICKS + 1);
    localparam int PERIOD [2] = '{NOTE_TICKS, SCAN_TICKS};

    logic [SEC_W-1:0] sec_cnt;
    logic [1:0] play_tick;

    // Free running from reset, drives the countdown
    assign sec_tick = (sec_cnt == SEC_W'(COUNT_TICKS - 1));

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            sec_cnt <= '0;
        end else if (sec_tick) begin
            sec_cnt <= '0;
        end else begin
            sec_cnt <= sec_cnt + 1'b1;
        end
    end

    // Note and scan counters, held at zero outside play
    for (genvar g = 0; g < 2; g++) begin : g_play_cnt
        logic [PLAY_W-1:0] cnt;

        assign play_tick[g] = (cnt == PLAY_W'(PERIOD[g] - 1));

        always_ff @(posedge prog_clk or posedge rst) begin
            if (rst) begin
                cnt <= '0;
            end else if (!step.play_en || play_tick[g]) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign step.note_tick = play_tick[0];
    assign step.scan_tick = play_tick[1];

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the rhythm_play testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rhythm_play \
    -f rhythm_play.f \
    -Mdir obj_dir

# Keep going on a nonzero exit so the log decides the result
./obj_dir/Vtb_rhythm_play > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "Testbench reported a failure, see sim.log"
    exit 1
fi

if ! grep -q "Simulation PASSED" sim.log; then
    echo "Simulation ended without a result, see sim.log"
    exit 1
fi

echo "Run complete"

/* tests/rhythm_play_checker.sv */
`timescale 1ns/100ps

module rhythm_play_checker (
    input logic                   prog_clk,
    input logic                   rst,
    input rhythm_pkg::cnt_digit_t cnt_dn,
    input logic                   playing,
    input logic                   to_menu,
    input logic                   save_strobe,
    input logic                   rec_we
);

    // Nothing leaves the block during the countdown
    a_quiet_countdown: assert property (
        @(posedge prog_clk) disable iff (rst)
        (cnt_dn != 2'd0 && !playing) |-> (!save_strobe && !rec_we)
    ) else $error("save or record strobe during countdown");

    // Only reset brings the game back from the menu request
    a_menu_held: assert property (
        @(posedge prog_clk) disable iff (rst)
        to_menu |=> to_menu
    ) else $error("to_menu fell without reset");

    a_rec_pulse: assert property (
        @(posedge prog_clk) disable iff (rst)
        rec_we |=> !rec_we
    ) else $error("rec_we longer than one cycle");

endmodule

bind rhythm_play rhythm_play_checker chk0 (
    .prog_clk    (prog_clk),
    .rst         (rst),
    .cnt_dn      (cnt_dn),
    .playing     (playing),
    .to_menu     (to_menu),
    .save_strobe (save_strobe),
    .rec_we      (rec_we)
);

/* tests/tb_rhythm_play.sv */
`timescale 1ns/100ps

module tb_rhythm_play;

    localparam int COUNT_TICKS = 8;
    localparam int NOTE_TICKS = 12;
    localparam int SCAN_TICKS = 4;
    localparam int CLK_PERIOD = 20;
    localparam int NUM_RUNS = 4;

    typedef struct packed {
        logic auto_play;
        rhythm_pkg::note_idx_t note_cnt;
        logic follow;
        rhythm_pkg::chart_id_t chart_id;
    } run_t;

    // auto_play, note_cnt, user follows the chart, save slot
    localparam run_t RUNS [NUM_RUNS] = '{
        '{1'b1, 16'd10, 1'b0, 8'h21},
        '{1'b0, 16'd12, 1'b1, 8'h5a},
        '{1'b0, 16'd7, 1'b0, 8'h03},
        '{1'b1, 16'd9, 1'b1, 8'hc4}
    };

    localparam logic [7:0] KEY_NAMES [7] = '{"c", "d", "e", "f", "g", "a", "b"};

    logic prog_clk;
    logic rst;
    logic [6:0] note_keys;
    logic oct_up;
    logic oct_down;
    logic key_left;
    logic key_right;
    logic auto_play;
    rhythm_pkg::chart_id_t chart_id;
    rhythm_pkg::note_idx_t note_cnt;
    rhythm_pkg::note_idx_t chart_addr;
    rhythm_pkg::note_t chart_note;
    rhythm_pkg::cnt_digit_t cnt_dn;
    logic playing;
    logic to_menu;
    rhythm_pkg::led_t led;
    rhythm_pkg::seg_text_t seg;
    rhythm_pkg::note_t played_note;
    logic rec_we;
    rhythm_pkg::note_idx_t rec_addr;
    rhythm_pkg::note_t rec_note;
    logic save_strobe;
    rhythm_pkg::chart_id_t save_chart_id;
    rhythm_pkg::score_t save_score;
    rhythm_pkg::score_t save_max;

    rhythm_pkg::note_t chart [32];
    logic [31:0] lfsr_state = 32'h06c333ee;

    rhythm_play #(
        .COUNT_TICKS (COUNT_TICKS),
        .NOTE_TICKS  (NOTE_TICKS),
        .SCAN_TICKS  (SCAN_TICKS)
    ) dut0 (.*);

    // Chart memory with asynchronous read
    assign chart_note = chart[chart_addr[4:0]];

    initial begin
        prog_clk = 1'b0;
        forever #(CLK_PERIOD / 2) prog_clk = ~prog_clk;
    end

    task automatic report_error(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t waiting for %s", $time, what);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_digit(input rhythm_pkg::cnt_digit_t got,
                               input rhythm_pkg::cnt_digit_t exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_led(input rhythm_pkg::led_t got, input rhythm_pkg::led_t exp,
                             input string what);
        if (got !== exp)
            report_error($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_seg(input rhythm_pkg::seg_text_t got,
                             input rhythm_pkg::seg_text_t exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s is \"%s\", expected \"%s\"", what, got, exp));
    endtask

    task automatic check_note(input rhythm_pkg::note_t got, input rhythm_pkg::note_t exp,
                              input string what);
        if (got !== exp)
            report_error($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    task automatic check_score(input rhythm_pkg::score_t got,
                               input rhythm_pkg::score_t exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_idx(input rhythm_pkg::note_idx_t got,
                             input rhythm_pkg::note_idx_t exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_id(input rhythm_pkg::chart_id_t got,
                            input rhythm_pkg::chart_id_t exp, input string what);
        if (got !== exp)
            report_error($sformatf("%s is %h, expected %h", what, got, exp));
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[6:0], lfsr_state[0]};
        end
    endtask

    // Mix of single keys, an invalid chord, and a rest every fourth entry
    task automatic fill_chart();
        logic [7:0] oct;
        logic [7:0] pick;
        logic [6:0] keys;
        for (int i = 0; i < 32; i++) begin
            take_bits(2, oct);
            keys = '0;
            if (i % 4 != 3) begin
                take_bits(3, pick);
                keys = (pick[2:0] == 3'd7) ? 7'b0100101 : 7'(1 << pick[2:0]);
            end
            chart[i] = {oct[1:0], keys};
        end
    endtask

    function automatic rhythm_pkg::led_t led_model(input rhythm_pkg::note_t n);
        rhythm_pkg::led_t v;
        v = '0;
        v[0] = (n[8:7] == 2'b01) || (n[8:7] == 2'b10);
        if ($countones(n[6:0]) == 1) begin
            for (int i = 0; i < 7; i++)
                v[7 - i] = n[i];
        end
        return v;
    endfunction

    function automatic rhythm_pkg::seg_text_t seg_model(input rhythm_pkg::note_t n);
        rhythm_pkg::seg_text_t v;
        logic [7:0] oct_char;
        int k;
        v = "        ";
        k = -1;
        for (int i = 0; i < 7; i++) begin
            if (n[6:0] == 7'(1 << i))
                k = i;
        end
        if (k >= 0 && n[8:7] != 2'b11) begin
            oct_char = n[7] ? "u" : (n[8] ? "d" : " ");
            v = {KEY_NAMES[k], " ", oct_char, " ", 8'("1" + k), "   "};
        end
        return v;
    endfunction

    task automatic next_cycle();
        @(posedge prog_clk);
        #2;
    endtask

    task automatic drive_keys(input rhythm_pkg::note_t n);
        {oct_down, oct_up, note_keys} = n;
    endtask

    task automatic play_run(input run_t r);
        int writes;
        int cycles;
        int scored;
        logic prev_playing;
        rhythm_pkg::note_idx_t prev_addr;
        rhythm_pkg::note_t prev_keys;
        rhythm_pkg::note_t keys;
        rhythm_pkg::score_t exp_max;
        rhythm_pkg::score_t exp_score;

        auto_play = r.auto_play;
        note_cnt = r.note_cnt;
        chart_id = r.chart_id;
        drive_keys('0);
        key_left = 1'b0;
        key_right = 1'b0;
        rst = 1'b1;
        repeat (5) next_cycle();
        check_digit(cnt_dn, 2'd3, "cnt_dn in reset");
        check_bit(playing, 1'b0, "playing in reset");
        check_bit(to_menu, 1'b0, "to_menu in reset");
        check_bit(save_strobe, 1'b0, "save_strobe in reset");
        check_bit(rec_we, 1'b0, "rec_we in reset");
        check_led(led, '0, "led in reset");
        check_seg(seg, "        ", "seg in reset");
        rst = 1'b0;

        // One digit per COUNT_TICKS cycles, then play
        // Save key held while digits are nonzero must not save
        for (int k = 1; k <= 4 * COUNT_TICKS; k++) begin
            next_cycle();
            check_digit(cnt_dn, (k >= 3 * COUNT_TICKS) ? 2'd0 : 2'(3 - k / COUNT_TICKS),
                        "cnt_dn");
            check_bit(playing, k == 4 * COUNT_TICKS, "playing");
            check_bit(save_strobe, 1'b0, "save_strobe in countdown");
            key_right = (k < 3 * COUNT_TICKS);
        end

        prev_playing = 1'b1;
        prev_addr = chart_addr;
        keys = r.follow ? chart[chart_addr[4:0]] : '0;
        drive_keys(keys);
        prev_keys = keys;
        writes = 0;
        cycles = 0;
        while (prev_playing) begin
            next_cycle();
            cycles++;
            if (cycles > r.note_cnt * NOTE_TICKS + 10)
                report_timeout("playing to fall");
            check_led(led, led_model(chart[prev_addr[4:0]]), "led");
            check_seg(seg, seg_model(chart[prev_addr[4:0]]), "seg");
            if (rec_we) begin
                check_idx(rec_addr, rhythm_pkg::note_idx_t'(writes), "rec_addr");
                check_note(rec_note, prev_keys, "rec_note");
                check_note(played_note, r.auto_play ? chart[prev_addr[4:0]] : prev_keys,
                           "played_note");
                writes++;
            end
            check_idx(chart_addr, rhythm_pkg::note_idx_t'(writes), "chart_addr");
            keys = r.follow ? chart[chart_addr[4:0]] : '0;
            drive_keys(keys);
            prev_keys = keys;
            prev_addr = chart_addr;
            prev_playing = playing;
        end
        check_idx(rhythm_pkg::note_idx_t'(writes), r.note_cnt, "record writes at finish");

        // Scores follow from the scan count over non-rest notes
        scored = 0;
        for (int i = 0; i < r.note_cnt; i++) begin
            if (chart[i][6:0] != 7'd0)
                scored++;
        end
        exp_max = rhythm_pkg::score_t'(rhythm_pkg::MAX_STEP * (NOTE_TICKS / SCAN_TICKS) * scored);
        if (r.auto_play)
            exp_score = rhythm_pkg::score_t'(exp_max * 4 / 5);
        else if (r.follow)
            exp_score = exp_max;
        else
            exp_score = '0;

        drive_keys('0);
        key_right = 1'b1;
        cycles = 0;
        next_cycle();
        while (!save_strobe) begin
            cycles++;
            if (cycles > 4)
                report_timeout("save_strobe");
            next_cycle();
        end
        key_right = 1'b0;
        check_score(save_score, exp_score, "save_score");
        check_score(save_max, exp_max, "save_max");
        check_id(save_chart_id, r.chart_id, "save_chart_id");

        key_left = 1'b1;
        cycles = 0;
        next_cycle();
        while (!to_menu) begin
            cycles++;
            if (cycles > 4)
                report_timeout("to_menu");
            next_cycle();
        end
        key_left = 1'b0;
        repeat (3) begin
            next_cycle();
            check_bit(to_menu, 1'b1, "to_menu after exit");
        end
    endtask

    initial begin
        rst = 1'b1;
        note_keys = '0;
        oct_up = 1'b0;
        oct_down = 1'b0;
        key_left = 1'b0;
        key_right = 1'b0;
        auto_play = 1'b0;
        chart_id = '0;
        note_cnt = '0;
        fill_chart();
        for (int i = 0; i < NUM_RUNS; i++)
            play_run(RUNS[i]);
        $display("Simulation PASSED");
        $finish;
    end

    // Budget is countdown, notes and some slack per run
    initial begin
        int budget;
        budget = 100;
        for (int i = 0; i < NUM_RUNS; i++)
            budget += 4 * COUNT_TICKS + RUNS[i].note_cnt * NOTE_TICKS + 50;
        repeat (budget) @(posedge prog_clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", budget);
        $display("Simulation FAILED");
        $fatal(1, "watchdog");
    end

endmodule
